// File: bench/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input logic                      clk_i,
    input logic                      rstn_i,
    input logic                      redirect_i,
    input tartaruga_pkg::fetch_out_t out_o,
    input logic                      out_valid_o,
    input logic                      out_ready_i
);

    int fail_cnt = 0; // failed properties so far.

    // a stalled item holds until taken or flushed.
    property stall_hold_p;
        @(posedge clk_i) disable iff (!rstn_i)
            (out_valid_o && !out_ready_i && !redirect_i) |=> (out_valid_o && $stable(out_o));
    endproperty

    property reset_quiet_p;
        @(posedge clk_i) !rstn_i |-> !out_valid_o;
    endproperty

    property reset_exit_p;
        @(posedge clk_i) !rstn_i |=> !out_valid_o; // first cycle out of reset.
    endproperty

    stall_hold_a: assert property (stall_hold_p)
        else begin
            fail_cnt++;
            $error("stalled output changed before it was taken");
        end

    reset_quiet_a: assert property (reset_quiet_p)
        else begin
            fail_cnt++;
            $error("output valid high during reset");
        end

    reset_exit_a: assert property (reset_exit_p)
        else begin
            fail_cnt++;
            $error("output valid high in the first cycle after reset");
        end

endmodule

bind fetch_top fetch_checker i_checker (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .redirect_i  (redirect_i),
    .out_o       (out_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
);

// File: bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int MAX_CYCLES   = 3000; // about 200 deliveries at twice the miss latency.
    localparam int HIT_LATENCY  = 2;
    localparam int MISS_LATENCY = 3 + 4; // rom latency plus four.

    localparam tartaruga_pkg::bus32_t LOOP_PC = 32'h0000_0040;
    localparam tartaruga_pkg::bus32_t LRU_A   = 32'h0000_0200; // all three in set 0.
    localparam tartaruga_pkg::bus32_t LRU_B   = 32'h0000_0300;
    localparam tartaruga_pkg::bus32_t LRU_C   = 32'h0000_0500;

    logic                      clk_i;
    logic                      rstn_i;
    logic                      redirect_i;
    tartaruga_pkg::bus32_t     redirect_pc_i;
    tartaruga_pkg::fetch_out_t out_o;
    logic                      out_valid_o;
    logic                      out_ready_i;

    tartaruga_pkg::instruction_t ref_mem [64];
    tartaruga_pkg::bus32_t       expect_pc = tartaruga_pkg::RESET_PC;

    int   cycle           = 0;
    int   xfer_cnt        = 0;
    int   fresh_cnt       = 0; // first transfers after a redirect.
    int   redir_cycle     = 0;
    int   last_xfer_cycle = 0;
    int   last_latency    = 0;
    int   seed            = 32'h1658;
    logic after_redir     = 1'b0;
    logic thru_check      = 1'b0;

    fetch_top i_dut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .out_o         (out_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("error: %s expected %h actual %h", test, expected, actual);
        abort_run();
    endtask

    task automatic wait_xfers(input int n);
        int target;
        target = xfer_cnt + n;
        while (xfer_cnt < target) begin
            @(posedge clk_i);
        end
    endtask

    task automatic redirect_to(input tartaruga_pkg::bus32_t pc);
        redirect_i    <= 1'b1;
        redirect_pc_i <= pc;
        @(posedge clk_i);
        redirect_i <= 1'b0;
    endtask

    task automatic jump_and_wait(input tartaruga_pkg::bus32_t pc);
        int n;
        n = fresh_cnt;
        redirect_to(pc);
        while (fresh_cnt == n) begin
            @(posedge clk_i);
        end
    endtask

    // stall the stream until no lookup is left in flight.
    task automatic drain_fetch();
        out_ready_i <= 1'b0;
        @(posedge clk_i);
        while (i_dut.fetch_req.valid) begin
            @(posedge clk_i);
        end
    endtask

    task automatic probe(input tartaruga_pkg::bus32_t pc, output int lat);
        drain_fetch();
        out_ready_i <= 1'b1;
        jump_and_wait(pc);
        lat = last_latency;
    endtask

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
        if (i_dut.i_checker.fail_cnt != 0) begin
            $display("a bound assertion on the fetch stream failed");
            abort_run();
        end
        if (rstn_i && out_valid_o && out_ready_i) begin
            assert (out_o.instr == ref_mem[out_o.pc[7:2]])
                else fail_value("instr_contents", ref_mem[out_o.pc[7:2]], out_o.instr);
            assert (out_o.pc == expect_pc)
                else fail_value("pc_order", expect_pc, out_o.pc);
            if (thru_check && out_o.pc > LOOP_PC && out_o.pc < LOOP_PC + 32'd32) begin
                assert (cycle == last_xfer_cycle + 1)
                    else fail_value("hit_throughput", last_xfer_cycle + 1, cycle);
            end
            if (after_redir) begin
                last_latency <= cycle - redir_cycle;
                fresh_cnt    <= fresh_cnt + 1;
                after_redir  <= 1'b0;
            end
            expect_pc       <= expect_pc + 32'd4;
            xfer_cnt        <= xfer_cnt + 1;
            last_xfer_cycle <= cycle;
        end
        if (rstn_i && redirect_i) begin
            expect_pc   <= redirect_pc_i; // overrides the sequential step.
            redir_cycle <= cycle;
            after_redir <= 1'b1;
        end
    end

    initial begin
        int lat;
        int rnd;
        $readmemh("rom.hex", ref_mem);
        rstn_i        = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        out_ready_i   = 1'b1;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;

        wait_xfers(12); // cold misses from the reset pc.

        // the 8-word loop is fetched twice.
        jump_and_wait(LOOP_PC);
        wait_xfers(7);
        thru_check <= 1'b1;
        jump_and_wait(LOOP_PC);
        wait_xfers(7);
        thru_check <= 1'b0;

        out_ready_i <= 1'b0;
        @(posedge clk_i);
        while (!out_valid_o) begin
            @(posedge clk_i);
        end
        redirect_to(32'h0000_00c0); // while the output is held.
        out_ready_i <= 1'b1;
        wait_xfers(4);

        probe(LRU_A, lat);
        probe(LRU_B, lat);
        probe(LRU_A, lat);
        assert (lat == HIT_LATENCY) else fail_value("lru_replacement", HIT_LATENCY, lat);
        probe(LRU_C, lat); // evicts B.
        probe(LRU_A, lat);
        assert (lat == HIT_LATENCY) else fail_value("lru_replacement", HIT_LATENCY, lat);
        probe(LRU_B, lat);
        assert (lat == MISS_LATENCY) else fail_value("lru_replacement", MISS_LATENCY, lat);

        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            out_ready_i   <= rnd[0];
            redirect_i    <= (i == 60) || (i == 140);
            redirect_pc_i <= (i < 100) ? 32'h0000_0084 : 32'h0000_00f0;
            @(posedge clk_i);
        end

        out_ready_i <= 1'b1;
        redirect_i  <= 1'b0;
        wait_xfers(4);
        if (i_dut.i_checker.fail_cnt != 0) begin
            $display("a bound assertion failed near the end of the run");
            abort_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: rom.hex
// one 32-bit instruction word per line, word index 0 to 63 (addi x1, x0, index)
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00a00093
00b00093
00c00093
00d00093
00e00093
00f00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01a00093
01b00093
01c00093
01d00093
01e00093
01f00093
02000093
02100093
02200093
02300093
02400093
02500093
02600093
02700093
02800093
02900093
02a00093
02b00093
02c00093
02d00093
02e00093
02f00093
03000093
03100093
03200093
03300093
03400093
03500093
03600093
03700093
03800093
03900093
03a00093
03b00093
03c00093
03d00093
03e00093
03f00093

// File: run.sh
#!/bin/sh
# build and run the fetch testbench, the log decides the verdict.
verilator --binary --timing --assert --timescale 1ns/1ps --top-module fetch_tb \
    -f sources.f -o fetch_sim || { echo "build failed"; exit 1; }
./obj_dir/fetch_sim +verilator+error+limit+10 > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: sources.f
verilog/tartaruga_pkg.sv
verilog/fetch_unit.sv
verilog/icache.sv
verilog/instr_rom.sv
verilog/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int NUM_SETS      = 16,
    parameter int ASSOCIATIVITY = 2,
    parameter int ROM_LATENCY   = 3,
    parameter int ROM_WORDS     = 64
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      redirect_i,
    input  tartaruga_pkg::bus32_t     redirect_pc_i,
    output tartaruga_pkg::fetch_out_t out_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i
);

    tartaruga_pkg::fetch_req_t fetch_req;
    tartaruga_pkg::fetch_rsp_t fetch_rsp;
    tartaruga_pkg::mem_req_t   mem_req;
    tartaruga_pkg::mem_rsp_t   mem_rsp;

    fetch_unit i_fetch_unit (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .req_o         (fetch_req),
        .rsp_i         (fetch_rsp),
        .out_o         (out_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i)
    );

    icache #(
        .NUM_SETS      (NUM_SETS),
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) i_icache (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req_i     (fetch_req),
        .rsp_o     (fetch_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    instr_rom #(
        .ROM_WORDS   (ROM_WORDS),
        .ROM_LATENCY (ROM_LATENCY)
    ) i_instr_rom (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      redirect_i,
    input  tartaruga_pkg::bus32_t     redirect_pc_i,
    output tartaruga_pkg::fetch_req_t req_o,
    input  tartaruga_pkg::fetch_rsp_t rsp_i,
    output tartaruga_pkg::fetch_out_t out_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i
);

    tartaruga_pkg::bus32_t     pc_q;      // next pc to look up.
    tartaruga_pkg::bus32_t     lk_pc_q;   // pc of the lookup in flight.
    tartaruga_pkg::bus32_t     fetch_pc;
    logic                      busy_q;
    logic                      stale_q;
    logic                      waiting;
    logic                      rsp_keep;
    logic                      take;
    logic                      issue;
    tartaruga_pkg::fetch_out_t new_item;
    tartaruga_pkg::fetch_out_t out_q;
    tartaruga_pkg::fetch_out_t out_d;
    tartaruga_pkg::fetch_out_t skid_q;
    tartaruga_pkg::fetch_out_t skid_d;
    logic                      out_valid_q;
    logic                      out_valid_d;
    logic                      skid_valid_q;
    logic                      skid_valid_d;

    assign waiting  = busy_q && !rsp_i.valid;
    assign rsp_keep = rsp_i.valid && !stale_q && !redirect_i;
    assign take     = out_valid_q && out_ready_i;
    assign fetch_pc = redirect_i ? redirect_pc_i : pc_q;
    assign issue    = !waiting && !skid_valid_d; // its answer must find room.

    assign new_item.pc    = lk_pc_q;
    assign new_item.instr = rsp_i.instr;

    always_comb begin
        req_o.valid = waiting || issue;
        req_o.pc    = waiting ? lk_pc_q : fetch_pc;
    end

    // out register in front, skid entry behind it.
    always_comb begin
        out_valid_d  = out_valid_q;
        out_d        = out_q;
        skid_valid_d = skid_valid_q;
        skid_d       = skid_q;
        if (take) begin
            out_valid_d  = skid_valid_q;
            out_d        = skid_q;
            skid_valid_d = 1'b0;
        end
        if (rsp_keep) begin
            if (!out_valid_d) begin
                out_valid_d = 1'b1;
                out_d       = new_item;
            end else begin
                skid_valid_d = 1'b1;
                skid_d       = new_item;
            end
        end
        if (redirect_i) begin
            out_valid_d  = 1'b0; // drop everything not yet taken.
            skid_valid_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q         <= tartaruga_pkg::RESET_PC;
            busy_q       <= 1'b0;
            stale_q      <= 1'b0;
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            busy_q       <= waiting || issue;
            stale_q      <= waiting && (stale_q || redirect_i);
            out_valid_q  <= out_valid_d;
            skid_valid_q <= skid_valid_d;
            if (issue) begin
                pc_q <= fetch_pc + 32'd4;
            end else if (redirect_i) begin
                pc_q <= redirect_pc_i; // held until the stale answer returns.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        out_q  <= out_d;
        skid_q <= skid_d;
        if (issue) begin
            lk_pc_q <= fetch_pc;
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

// File: verilog/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int NUM_SETS      = 16,
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  tartaruga_pkg::fetch_req_t req_i,
    output tartaruga_pkg::fetch_rsp_t rsp_o,
    output tartaruga_pkg::mem_req_t   mem_req_o,
    input  tartaruga_pkg::mem_rsp_t   mem_rsp_i
);

    localparam int OFFSET_BITS = 2;
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int WAY_BITS    = (ASSOCIATIVITY > 1) ? $clog2(ASSOCIATIVITY) : 1;

    typedef struct packed {
        logic [TAG_BITS-1:0]         tag;
        tartaruga_pkg::instruction_t data;
    } line_t;

    line_t               line_mem [NUM_SETS][ASSOCIATIVITY];
    logic                valid_q  [NUM_SETS][ASSOCIATIVITY];
    logic [WAY_BITS-1:0] rank_q   [NUM_SETS][ASSOCIATIVITY]; // 0 is most recent.

    tartaruga_pkg::icache_state_e state_q;
    tartaruga_pkg::icache_state_e state_d;
    tartaruga_pkg::bus32_t        lk_pc_q;
    tartaruga_pkg::instruction_t  rsp_data_q;
    logic                         hit_q;

    logic [INDEX_BITS-1:0] lk_idx;
    logic [TAG_BITS-1:0]   lk_tag;
    logic [INDEX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0]   fill_tag;
    logic                  hit;
    logic [WAY_BITS-1:0]   hit_way;
    logic [WAY_BITS-1:0]   victim_way;
    logic                  accept;
    logic                  fill_ack;
    logic                  touch_en;
    logic [INDEX_BITS-1:0] touch_set;
    logic [WAY_BITS-1:0]   touch_way;
    logic [WAY_BITS-1:0]   touch_rank;

    assign lk_idx   = req_i.pc[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];
    assign lk_tag   = req_i.pc[31:OFFSET_BITS+INDEX_BITS];
    assign fill_idx = lk_pc_q[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];
    assign fill_tag = lk_pc_q[31:OFFSET_BITS+INDEX_BITS];

    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        victim_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (valid_q[lk_idx][w] && (line_mem[lk_idx][w].tag == lk_tag)) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
            if (rank_q[fill_idx][w] == WAY_BITS'(ASSOCIATIVITY - 1)) begin
                victim_way = WAY_BITS'(w); // least recently used.
            end
        end
    end

    assign accept   = (state_q == tartaruga_pkg::LOOKUP) && req_i.valid;
    assign fill_ack = (state_q == tartaruga_pkg::FILL_REQ) && mem_rsp_i.ack;

    // a hit and a fill update the ranks the same way.
    assign touch_en   = (accept && hit) || fill_ack;
    assign touch_set  = fill_ack ? fill_idx : lk_idx;
    assign touch_way  = fill_ack ? victim_way : hit_way;
    assign touch_rank = rank_q[touch_set][touch_way];

    always_comb begin
        state_d = state_q;
        case (state_q)
            tartaruga_pkg::LOOKUP: begin
                if (accept && !hit) begin
                    state_d = tartaruga_pkg::FILL_REQ;
                end
            end
            tartaruga_pkg::FILL_REQ: begin
                if (mem_rsp_i.ack) begin
                    state_d = tartaruga_pkg::FILL_REL;
                end
            end
            tartaruga_pkg::FILL_REL: begin
                if (!mem_rsp_i.ack) begin
                    state_d = tartaruga_pkg::LOOKUP;
                end
            end
            default: state_d = tartaruga_pkg::LOOKUP;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= tartaruga_pkg::LOOKUP;
            hit_q   <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < ASSOCIATIVITY; w++) begin
                    valid_q[s][w] <= 1'b0;
                    rank_q[s][w]  <= WAY_BITS'(w);
                end
            end
        end else begin
            state_q <= state_d;
            hit_q   <= accept && hit;
            if (fill_ack) begin
                valid_q[fill_idx][victim_way] <= 1'b1;
            end
            if (touch_en) begin
                for (int w = 0; w < ASSOCIATIVITY; w++) begin
                    if (WAY_BITS'(w) == touch_way) begin
                        rank_q[touch_set][w] <= '0;
                    end else if (rank_q[touch_set][w] < touch_rank) begin
                        rank_q[touch_set][w] <= rank_q[touch_set][w] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            lk_pc_q <= req_i.pc;
        end
        if (accept && hit) begin
            rsp_data_q <= line_mem[lk_idx][hit_way].data;
        end else if (fill_ack) begin
            rsp_data_q <= mem_rsp_i.data;
        end
        if (fill_ack) begin
            line_mem[fill_idx][victim_way].tag  <= fill_tag;
            line_mem[fill_idx][victim_way].data <= mem_rsp_i.data;
        end
    end

    // fill answers once the rom has released ack.
    assign rsp_o.valid = hit_q || ((state_q == tartaruga_pkg::FILL_REL) && !mem_rsp_i.ack);
    assign rsp_o.instr = rsp_data_q;

    assign mem_req_o.req  = (state_q == tartaruga_pkg::FILL_REQ);
    assign mem_req_o.addr = lk_pc_q;

endmodule

// File: verilog/instr_rom.sv
`timescale 1ns/1ps

module instr_rom #(
    parameter int ROM_WORDS   = 64,
    parameter int ROM_LATENCY = 3
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  tartaruga_pkg::mem_req_t mem_req_i,
    output tartaruga_pkg::mem_rsp_t mem_rsp_o
);

    localparam int CNT_BITS = $clog2(ROM_LATENCY + 1);
    localparam int IDX_BITS = (ROM_WORDS > 1) ? $clog2(ROM_WORDS) : 1;

    tartaruga_pkg::instruction_t rom_mem [ROM_WORDS];
    tartaruga_pkg::instruction_t data_q;
    logic [CNT_BITS-1:0]         wait_cnt_q;
    logic [IDX_BITS-1:0]         word_idx;
    logic                        ack_q;
    logic                        fire;

    initial begin
        $readmemh("rom.hex", rom_mem);
    end

    assign word_idx = IDX_BITS'((mem_req_i.addr >> 2) % ROM_WORDS);
    assign fire     = mem_req_i.req && !ack_q && (wait_cnt_q == CNT_BITS'(ROM_LATENCY - 1));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_q      <= 1'b0;
            wait_cnt_q <= '0;
        end else if (!mem_req_i.req) begin
            ack_q      <= 1'b0; // release one cycle after req drops.
            wait_cnt_q <= '0;
        end else if (fire) begin
            ack_q <= 1'b1;
        end else if (!ack_q) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            data_q <= rom_mem[word_idx];
        end
    end

    assign mem_rsp_o.ack  = ack_q;
    assign mem_rsp_o.data = data_q;

endmodule

// File: verilog/tartaruga_pkg.sv
package tartaruga_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [31:0] instruction_t;

    localparam bus32_t RESET_PC = 32'h0000_0000;

    typedef struct packed {
        logic   valid;
        bus32_t pc;
    } fetch_req_t;

    typedef struct packed {
        logic         valid;
        instruction_t instr;
    } fetch_rsp_t;

    typedef struct packed {
        bus32_t       pc;
        instruction_t instr;
    } fetch_out_t;

    // four-phase link toward the rom.
    typedef struct packed {
        logic   req;
        bus32_t addr;
    } mem_req_t;

    typedef struct packed {
        logic         ack;
        instruction_t data;
    } mem_rsp_t;

    typedef enum logic [1:0] {LOOKUP, FILL_REQ, FILL_REL} icache_state_e;

endpackage
